//--- Makefile
# Verilator build and run for the ITIM testbench

SIM = obj_dir/Vtb_itim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_itim -f list.f

run: compile
	$(SIM) | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
	  echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" sim.log; then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- itim.sv
`default_nettype none

module itim #(
  parameter int itim_depth = 64,
  parameter int itim_banks = 4,
  parameter logic [itim_pkg::addr_bits-1:0] itim_base = 32'h0000_1000,
  parameter logic [itim_pkg::addr_bits-1:0] itim_top = 32'h0000_2000
) (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic fetch_fence,
  input logic [itim_pkg::addr_bits-1:0] fetch_addr,
  output logic [itim_pkg::fetch_bits-1:0] fetch_rdata,
  output logic fetch_ready,
  output logic imem_valid,
  output logic [itim_pkg::addr_bits-1:0] imem_addr,
  input logic [itim_pkg::word_bits-1:0] imem_rdata,
  input logic imem_ready
);

  import itim_pkg::*;

  localparam int row_bits = $clog2(itim_depth);
  localparam int tag_bits = addr_bits - offset_bits - $clog2(itim_banks) - row_bits;

  // Lock bit marks a row filled since the last fence
  typedef struct packed {
    logic lock;
    logic [tag_bits-1:0] tag;
  } tag_entry_t;

  logic tag_wen [itim_banks];
  logic [row_bits-1:0] tag_waddr [itim_banks];
  tag_entry_t tag_wdata [itim_banks];
  logic [row_bits-1:0] tag_raddr [itim_banks];
  tag_entry_t tag_rdata [itim_banks];

  logic data_wen [itim_banks];
  logic [row_bits-1:0] data_waddr [itim_banks];
  word_t data_wdata [itim_banks];
  logic [row_bits-1:0] data_raddr [itim_banks];
  word_t data_rdata [itim_banks];

  for (genvar i = 0; i < itim_banks; i++) begin : g_tag
    itim_ram #(
      .depth(itim_depth),
      .payload_t(tag_entry_t)
    ) tag_ram (
      .clock(clock),
      .wen(tag_wen[i]),
      .waddr(tag_waddr[i]),
      .raddr(tag_raddr[i]),
      .wdata(tag_wdata[i]),
      .rdata(tag_rdata[i])
    );
  end

  for (genvar i = 0; i < itim_banks; i++) begin : g_data
    itim_ram #(
      .depth(itim_depth),
      .payload_t(word_t)
    ) data_ram (
      .clock(clock),
      .wen(data_wen[i]),
      .waddr(data_waddr[i]),
      .raddr(data_raddr[i]),
      .wdata(data_wdata[i]),
      .rdata(data_rdata[i])
    );
  end

  itim_ctrl #(
    .itim_depth(itim_depth),
    .itim_banks(itim_banks),
    .itim_base(itim_base),
    .itim_top(itim_top),
    .tag_t(tag_entry_t)
  ) ctrl (
    .clock(clock),
    .reset(reset),
    .fetch_valid(fetch_valid),
    .fetch_fence(fetch_fence),
    .fetch_addr(fetch_addr),
    .fetch_rdata(fetch_rdata),
    .fetch_ready(fetch_ready),
    .imem_rdata(imem_rdata),
    .imem_ready(imem_ready),
    .imem_valid(imem_valid),
    .imem_addr(imem_addr),
    .tag_wen(tag_wen),
    .tag_waddr(tag_waddr),
    .tag_wdata(tag_wdata),
    .tag_raddr(tag_raddr),
    .tag_rdata(tag_rdata),
    .data_wen(data_wen),
    .data_waddr(data_waddr),
    .data_wdata(data_wdata),
    .data_raddr(data_raddr),
    .data_rdata(data_rdata)
  );

endmodule

`default_nettype wire

//--- itim_ctrl.sv
`default_nettype none

module itim_ctrl #(
  parameter int itim_depth = 64,
  parameter int itim_banks = 4,
  parameter logic [itim_pkg::addr_bits-1:0] itim_base = 32'h0000_1000,
  parameter logic [itim_pkg::addr_bits-1:0] itim_top = 32'h0000_2000,
  parameter type tag_t = logic [itim_pkg::addr_bits - itim_pkg::offset_bits
    - $clog2(itim_banks) - $clog2(itim_depth):0]
) (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic fetch_fence,
  input logic [itim_pkg::addr_bits-1:0] fetch_addr,
  output logic [itim_pkg::fetch_bits-1:0] fetch_rdata,
  output logic fetch_ready,
  input logic [itim_pkg::word_bits-1:0] imem_rdata,
  input logic imem_ready,
  output logic imem_valid,
  output logic [itim_pkg::addr_bits-1:0] imem_addr,
  output logic tag_wen [itim_banks],
  output logic [$clog2(itim_depth)-1:0] tag_waddr [itim_banks],
  output tag_t tag_wdata [itim_banks],
  output logic [$clog2(itim_depth)-1:0] tag_raddr [itim_banks],
  input tag_t tag_rdata [itim_banks],
  output logic data_wen [itim_banks],
  output logic [$clog2(itim_depth)-1:0] data_waddr [itim_banks],
  output logic [itim_pkg::word_bits-1:0] data_wdata [itim_banks],
  output logic [$clog2(itim_depth)-1:0] data_raddr [itim_banks],
  input logic [itim_pkg::word_bits-1:0] data_rdata [itim_banks]
);

  import itim_pkg::*;

  localparam int bank_bits = $clog2(itim_banks);
  localparam int row_bits = $clog2(itim_depth);
  localparam int tag_bits = addr_bits - offset_bits - bank_bits - row_bits;
  localparam logic [row_bits-1:0] last_row = row_bits'(itim_depth - 1);

  function automatic logic [bank_bits-1:0] bank_of(input logic [addr_bits-1:0] addr);
    return addr[offset_bits +: bank_bits];
  endfunction

  function automatic logic [row_bits-1:0] row_of(input logic [addr_bits-1:0] addr);
    return addr[offset_bits + bank_bits +: row_bits];
  endfunction

  function automatic logic [tag_bits-1:0] tag_of(input logic [addr_bits-1:0] addr);
    return addr[addr_bits-1 -: tag_bits];
  endfunction

  logic [addr_bits-1:0] fetch_next;
  logic front_valid;
  logic front_fence;
  logic [addr_bits-1:0] front_addr0;
  logic [addr_bits-1:0] front_addr1;

  logic [tag_bits:0] entry0;
  logic [tag_bits:0] entry1;
  logic [word_bits-1:0] word0;
  logic [word_bits-1:0] word1;
  logic in_window;
  logic present;

  itim_state_t state;
  itim_state_t state_d;
  logic second;
  logic second_d;
  logic valid_d;
  logic [addr_bits-1:0] addr_d;
  logic [word_bits-1:0] rdata_lo;
  logic [word_bits-1:0] lo_d;
  logic [row_bits-1:0] fence_row;
  logic [row_bits-1:0] fence_row_d;
  logic start_mem;
  logic fill;
  logic sweep;
  logic [bank_bits-1:0] fill_bank;

  // Read rows follow the incoming address directly
  assign fetch_next = fetch_addr + word_bytes;

  always_comb begin
    for (int i = 0; i < itim_banks; i++) begin
      tag_raddr[i] = '0;
      data_raddr[i] = '0;
    end
    tag_raddr[bank_of(fetch_addr)] = row_of(fetch_addr);
    data_raddr[bank_of(fetch_addr)] = row_of(fetch_addr);
    // Second word always sits in the next bank
    tag_raddr[bank_of(fetch_next)] = row_of(fetch_next);
    data_raddr[bank_of(fetch_next)] = row_of(fetch_next);
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      front_valid <= 1'b0;
      front_fence <= 1'b0;
    end else begin
      front_valid <= fetch_valid;
      front_fence <= fetch_valid & fetch_fence;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_valid) begin
      front_addr0 <= fetch_addr;
      front_addr1 <= fetch_next;
    end
  end

  // Bank outputs line up with the registered request
  assign entry0 = tag_rdata[bank_of(front_addr0)];
  assign entry1 = tag_rdata[bank_of(front_addr1)];
  assign word0 = data_rdata[bank_of(front_addr0)];
  assign word1 = data_rdata[bank_of(front_addr1)];

  assign in_window = front_addr0 >= itim_base && front_addr0 < itim_top &&
                     front_addr1 >= itim_base && front_addr1 < itim_top;

  // Both words locked and tagged with this address
  assign present = entry0[tag_bits] && entry1[tag_bits] &&
                   entry0[tag_bits-1:0] == tag_of(front_addr0) &&
                   entry1[tag_bits-1:0] == tag_of(front_addr1);

  always_comb begin
    state_d = state;
    second_d = second;
    valid_d = imem_valid;
    addr_d = imem_addr;
    lo_d = rdata_lo;
    fence_row_d = fence_row;
    start_mem = 1'b0;
    fill = 1'b0;
    sweep = 1'b0;
    fetch_ready = 1'b0;
    fetch_rdata = '0;
    case (state)
      state_hit: begin
        if (front_valid) begin
          if (front_fence) begin
            state_d = state_fence;
            fence_row_d = '0;
          end else if (!in_window) begin
            state_d = state_load;
            start_mem = 1'b1;
          end else if (!present) begin
            // Unlocked rows and foreign tags both refill the pair
            state_d = state_miss;
            start_mem = 1'b1;
          end else begin
            fetch_ready = 1'b1;
            fetch_rdata = {word1, word0};
          end
        end
      end
      state_miss, state_load: begin
        fill = state == state_miss && imem_ready;
        if (imem_ready) begin
          if (second) begin
            state_d = state_hit;
            second_d = 1'b0;
            valid_d = 1'b0;
            fetch_ready = 1'b1;
            fetch_rdata = {imem_rdata, rdata_lo};
          end else begin
            second_d = 1'b1;
            addr_d = front_addr1;
            lo_d = imem_rdata;
          end
        end
      end
      state_fence: begin
        sweep = 1'b1;
        if (fence_row == last_row) begin
          state_d = state_hit;
          fetch_ready = 1'b1;
        end else begin
          fence_row_d = fence_row + 1'b1;
        end
      end
      default: begin
        state_d = state_hit;
      end
    endcase
    if (start_mem) begin
      valid_d = 1'b1;
      addr_d = front_addr0;
      second_d = 1'b0;
    end
  end

  // Current memory word decides where a fill lands
  assign fill_bank = bank_of(imem_addr);

  always_comb begin
    for (int i = 0; i < itim_banks; i++) begin
      tag_wen[i] = sweep;
      tag_waddr[i] = fence_row;
      tag_wdata[i] = '0;
      data_wen[i] = sweep;
      data_waddr[i] = fence_row;
      data_wdata[i] = '0;
    end
    if (fill) begin
      tag_wen[fill_bank] = 1'b1;
      tag_waddr[fill_bank] = row_of(imem_addr);
      tag_wdata[fill_bank] = {1'b1, tag_of(imem_addr)};
      data_wen[fill_bank] = 1'b1;
      data_waddr[fill_bank] = row_of(imem_addr);
      data_wdata[fill_bank] = imem_rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= state_hit;
      second <= 1'b0;
      imem_valid <= 1'b0;
      fence_row <= '0;
    end else begin
      state <= state_d;
      second <= second_d;
      imem_valid <= valid_d;
      fence_row <= fence_row_d;
    end
  end

  always_ff @(posedge clock) begin
    imem_addr <= addr_d;
    rdata_lo <= lo_d;
  end

endmodule

`default_nettype wire

//--- itim_patterns.txt
// Columns: op, address, expected 64-bit data, expected memory words (all hex)
// op 0 is a fetch, op 1 is a fence, op 2 ends the list
// Miss, then hit on the same pair
0 00001000 FFFF1004FFFF1000 2
0 00001000 FFFF1004FFFF1000 0
0 00001008 FFFF100CFFFF1008 2
0 00001004 FFFF1008FFFF1004 0
// Outside the window, never cached
0 00003000 FFFF3004FFFF3000 2
0 00003000 FFFF3004FFFF3000 2
0 00000FFC FFFF1000FFFF0FFC 2
0 00000FFC FFFF1000FFFF0FFC 2
0 00001FFC FFFF2000FFFF1FFC 2
0 00001FFC FFFF2000FFFF1FFC 2
0 80001000 7FFF10047FFF1000 2
0 80001000 7FFF10047FFF1000 2
// Last bank into the next row
0 0000100C FFFF1010FFFF100C 2
0 0000100C FFFF1010FFFF100C 0
0 00001010 FFFF1014FFFF1010 2
0 00001010 FFFF1014FFFF1010 0
// Top row of the window
0 00001FF8 FFFF1FFCFFFF1FF8 2
0 00001FF8 FFFF1FFCFFFF1FF8 0
// Fence clears everything
1 00000000 0000000000000000 0
0 00001000 FFFF1004FFFF1000 2
0 00001000 FFFF1004FFFF1000 0
0 0000100C FFFF1010FFFF100C 2
// Same row and bank, different tags
0 00001400 FFFF1404FFFF1400 2
0 00001000 FFFF1004FFFF1000 2
0 00001400 FFFF1404FFFF1400 2
0 00001000 FFFF1004FFFF1000 2
0 00001000 FFFF1004FFFF1000 0
// Second fence, then refill
1 00001234 0000000000000000 0
0 00001FF8 FFFF1FFCFFFF1FF8 2
0 00001FF8 FFFF1FFCFFFF1FF8 0
2 00000000 0000000000000000 0

//--- itim_pkg.sv
`default_nettype none

package itim_pkg;

  // Instruction word and address
  localparam int word_bits = 32;
  localparam int addr_bits = 32;

  // Two words go back to the core per fetch
  localparam int fetch_bits = 2 * word_bits;

  // Byte offset inside one word
  localparam int offset_bits = $clog2(word_bits / 8);

  // Step from the first word of a pair to the second
  localparam logic [addr_bits-1:0] word_bytes = addr_bits'(word_bits / 8);

  // Payload of one data bank row
  typedef logic [word_bits-1:0] word_t;

  // Controller states
  //   hit   waits for a request, answers hits directly
  //   miss  fetches two words and writes them into the banks
  //   load  fetches two words and only passes them on
  //   fence clears one row of every bank per cycle
  typedef enum logic [1:0] {
    state_hit = 2'd0,
    state_miss = 2'd1,
    state_load = 2'd2,
    state_fence = 2'd3
  } itim_state_t;

endpackage

`default_nettype wire

//--- itim_properties.sv
`default_nettype none

module itim_properties (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic fetch_ready,
  input logic imem_valid,
  input logic [itim_pkg::addr_bits-1:0] imem_addr,
  input logic imem_ready
);

  timeunit 1ns;
  timeprecision 100ps;

  logic pending;

  // Outstanding from the strobe until fetch_ready
  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
    end else if (fetch_valid) begin
      pending <= 1'b1;
    end else if (fetch_ready) begin
      pending <= 1'b0;
    end
  end

  ready_needs_fetch: assert property (
    @(posedge clock) disable iff (!reset) fetch_ready |-> pending
  ) else $error("fetch_ready high with no fetch outstanding");

  addr_held: assert property (
    @(posedge clock) disable iff (!reset) imem_valid && !imem_ready |=> $stable(imem_addr)
  ) else $error("imem_addr changed while waiting for imem_ready");

  valid_low_after_reset: assert property (
    @(posedge clock) !reset |=> !imem_valid
  ) else $error("imem_valid high right after reset");

endmodule

bind itim itim_properties props (
  .clock(clock),
  .reset(reset),
  .fetch_valid(fetch_valid),
  .fetch_ready(fetch_ready),
  .imem_valid(imem_valid),
  .imem_addr(imem_addr),
  .imem_ready(imem_ready)
);

`default_nettype wire

//--- itim_ram.sv
`default_nettype none

module itim_ram #(
  parameter int depth = 64,
  parameter type payload_t = logic [31:0]
) (
  input logic clock,
  input logic wen,
  input logic [$clog2(depth)-1:0] waddr,
  input logic [$clog2(depth)-1:0] raddr,
  input payload_t wdata,
  output payload_t rdata
);

  payload_t mem [depth];
  logic [$clog2(depth)-1:0] raddr_q;

  // Rows start out cleared, so every entry is unlocked
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
    raddr_q <= raddr;
  end

  // Data follows the registered read row by one cycle
  assign rdata = mem[raddr_q];

endmodule

`default_nettype wire

//--- list.f
itim_pkg.sv
itim_ram.sv
itim_ctrl.sv
itim.sv
itim_properties.sv
tb_itim.sv

//--- tb_itim.sv
`default_nettype none

module tb_itim;

  timeunit 1ns;
  timeprecision 100ps;

  import itim_pkg::*;

  localparam int itim_depth = 64;
  localparam int itim_banks = 4;
  localparam int max_lines = 64;
  localparam int fields = 4;

  // Operation codes in the pattern file
  localparam logic [63:0] op_fetch = 64'd0;
  localparam logic [63:0] op_fence = 64'd1;

  logic clock;
  logic reset;
  logic fetch_valid;
  logic fetch_fence;
  logic [addr_bits-1:0] fetch_addr;
  logic [fetch_bits-1:0] fetch_rdata;
  logic fetch_ready;
  logic imem_valid;
  logic [addr_bits-1:0] imem_addr;
  logic [word_bits-1:0] imem_rdata = '0;
  logic imem_ready = 1'b0;

  logic [63:0] patterns [fields * max_lines];
  int line_count;
  int cycle_limit = 0;
  int cycle_count = 0;
  int mem_delay = -1;

  itim #(
    .itim_depth(itim_depth),
    .itim_banks(itim_banks),
    .itim_base(32'h0000_1000),
    .itim_top(32'h0000_2000)
  ) dut0 (
    .clock(clock),
    .reset(reset),
    .fetch_valid(fetch_valid),
    .fetch_fence(fetch_fence),
    .fetch_addr(fetch_addr),
    .fetch_rdata(fetch_rdata),
    .fetch_ready(fetch_ready),
    .imem_valid(imem_valid),
    .imem_addr(imem_addr),
    .imem_rdata(imem_rdata),
    .imem_ready(imem_ready)
  );

  always #50 clock = ~clock;

  // Backing memory holds the address with its upper half inverted
  function automatic logic [31:0] memory_word(input logic [31:0] addr);
    return {~addr[31:16], addr[15:0]};
  endfunction

  // Each word is accepted after 0 to 3 idle cycles
  always @(posedge clock) begin
    #10;
    imem_ready = 1'b0;
    if (reset && imem_valid) begin
      if (mem_delay < 0) begin
        mem_delay = $urandom_range(3, 0);
      end
      if (mem_delay == 0) begin
        imem_ready = 1'b1;
        imem_rdata = memory_word(imem_addr);
        mem_delay = -1;
      end else begin
        mem_delay--;
      end
    end
  end

  always @(posedge clock) begin
    if (reset && cycle_limit > 0) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        $display("Timeout after %0d cycles, a fetch never completed", cycle_count);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation timed out");
      end
    end
  end

  task automatic value_error(input string name, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    $display("** Error %s %s: expected %h, actual %h", name, what, expected, actual);
    $display("ERRORS FOUND");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic run_pattern(input int index);
    logic [63:0] op;
    logic [31:0] addr;
    logic [63:0] expected;
    logic [63:0] expected_words;
    logic [63:0] rdata;
    logic last_accept;
    int words;
    int latency;
    string name;
    op = patterns[fields * index];
    addr = patterns[fields * index + 1][31:0];
    expected = patterns[fields * index + 2];
    expected_words = patterns[fields * index + 3];
    name = $sformatf("pattern %0d %s %h", index, op == op_fence ? "fence" : "fetch", addr);
    words = 0;
    latency = 0;
    last_accept = 1'b0;
    @(posedge clock);
    #10;
    fetch_valid = 1'b1;
    fetch_fence = op == op_fence;
    fetch_addr = addr;
    @(posedge clock);
    #10;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    // Sample mid cycle, where both strobes are settled
    do begin
      @(negedge clock);
      latency++;
      last_accept = imem_valid && imem_ready;
      if (last_accept) begin
        words++;
      end
      rdata = fetch_rdata;
    end while (!fetch_ready);
    assert (rdata === expected) else begin
      value_error(name, "data", expected, rdata);
    end
    assert (64'(words) == expected_words) else begin
      value_error(name, "memory words", expected_words, 64'(words));
    end
    // A hit answers in the cycle after the request
    if (op == op_fetch && expected_words == 0) begin
      assert (latency == 1) else begin
        value_error(name, "hit latency", 64'd1, 64'(latency));
      end
    end
    // A memory fetch ends together with the second word
    if (op == op_fetch && expected_words == 2) begin
      assert (last_accept) else begin
        value_error(name, "ready with last word", 64'd1, 64'(last_accept));
      end
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    fetch_addr = '0;
    void'($urandom(32'h7480));
    $readmemh("itim_patterns.txt", patterns);
    line_count = 0;
    while (line_count < max_lines &&
           (patterns[fields * line_count] === op_fetch ||
            patterns[fields * line_count] === op_fence)) begin
      line_count++;
    end
    cycle_limit = line_count * (2 * 4 + itim_depth + 8);
    repeat (16) @(posedge clock);
    #10;
    reset = 1'b1;
    for (int i = 0; i < line_count; i++) begin
      run_pattern(i);
    end
    if (line_count == 0) begin
      $display("No patterns were read from itim_patterns.txt");
      $display("ERRORS FOUND");
      $fatal(1, "Empty pattern file");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire
